/* mips_cpu_harvard.f */
+incdir+.
mips_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_regfile.sv
mips_execute.sv
mips_mem_writeback.sv
mips_cpu_harvard.sv
tb_mips_cpu_harvard.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mips_cpu_harvard \
  -f mips_cpu_harvard.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

/* tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Program numbers used by the test table
localparam logic [2:0] PROG_ALU  = 3'd0;
localparam logic [2:0] PROG_MEM  = 3'd1;
localparam logic [2:0] PROG_SLOT = 3'd2;
localparam logic [2:0] PROG_CALL = 3'd3;
localparam logic [2:0] PROG_MULT = 3'd4;

localparam logic [4:0] R_ZERO = 5'd0;
localparam logic [4:0] R_V0   = 5'd2;
localparam logic [4:0] R_T0   = 5'd8;
localparam logic [4:0] R_T1   = 5'd9;
localparam logic [4:0] R_T2   = 5'd10;
localparam logic [4:0] R_T3   = 5'd11;
localparam logic [4:0] R_S0   = 5'd16;
localparam logic [4:0] R_RA   = 5'd31;
localparam logic [4:0] NO_SH  = 5'd0;

function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [4:0] shamt,
                                       input funct_e fn);
  return {OP_SPECIAL, rs, rt, rd, shamt, fn};
endfunction

function automatic logic [31:0] i_type(input opcode_e op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

// Next free ROM word while a program is built
int prog_pos;

task automatic emit(input logic [31:0] word);
  rom[prog_pos] = word;
  prog_pos++;
endtask

// Result in t2, folded into v0
task automatic emit_fold(input logic [31:0] word);
  emit(word);
  emit(r_type(R_V0, R_T2, R_V0, NO_SH, FN_XOR));
endtask

// Patch points: operand a into t0, b into t1
task automatic emit_operands(input logic [31:0] a, input logic [31:0] b);
  emit(i_type(OP_LUI, R_ZERO, R_T0, a[31:16]));
  emit(i_type(OP_ORI, R_T0, R_T0, a[15:0]));
  emit(i_type(OP_LUI, R_ZERO, R_T1, b[31:16]));
  emit(i_type(OP_ORI, R_T1, R_T1, b[15:0]));
endtask

// jr $zero and its delay slot
task automatic emit_halt();
  emit(r_type(R_ZERO, R_ZERO, R_ZERO, NO_SH, FN_JR));
  emit(32'h0000_0000);
endtask

task automatic load_program(input logic [2:0] prog, input logic [31:0] a,
                            input logic [31:0] b, input logic [1:0] lane);
  logic [31:0] call_target;
  call_target = RESET_VECTOR + 32'd20;
  for (int i = 0; i < 1024; i++)
  begin
    rom[i] = 32'h0000_0000;
  end
  prog_pos = 0;
  case (prog)
    PROG_ALU:
    begin
      emit_operands(a, b);
      emit_fold(r_type(R_T0, R_T1, R_T2, NO_SH, FN_ADDU));
      emit_fold(r_type(R_T0, R_T1, R_T2, NO_SH, FN_SUBU));
      emit_fold(r_type(R_T0, R_T1, R_T2, NO_SH, FN_AND));
      emit_fold(r_type(R_T0, R_T1, R_T2, NO_SH, FN_OR));
      emit_fold(r_type(R_T0, R_T1, R_T2, NO_SH, FN_XOR));
      emit_fold(r_type(R_T0, R_T1, R_T2, NO_SH, FN_NOR));
      emit_fold(r_type(R_T0, R_T1, R_T2, NO_SH, FN_SLT));
      emit_fold(r_type(R_T0, R_T1, R_T2, NO_SH, FN_SLTU));
      emit_fold(r_type(R_ZERO, R_T1, R_T2, 5'd5, FN_SLL));
      emit_fold(r_type(R_ZERO, R_T1, R_T2, 5'd7, FN_SRL));
      emit_fold(r_type(R_ZERO, R_T1, R_T2, 5'd11, FN_SRA));
      emit_fold(i_type(OP_ADDIU, R_T0, R_T2, 16'h8765));
      emit_fold(i_type(OP_SLTI, R_T0, R_T2, 16'h8000));
      emit_fold(i_type(OP_SLTIU, R_T0, R_T2, 16'hFFF0));
      emit_fold(i_type(OP_ANDI, R_T0, R_T2, 16'hF0F0));
      emit_fold(i_type(OP_ORI, R_T0, R_T2, 16'h1234));
      emit_fold(i_type(OP_XORI, R_T0, R_T2, 16'hFF00));
      emit_fold(i_type(OP_LUI, R_ZERO, R_T2, 16'hBEEF));
      emit_halt();
    end
    PROG_MEM:
    begin
      emit_operands(a, b);
      emit(i_type(OP_ADDIU, R_ZERO, R_S0, 16'h0100));
      emit(i_type(OP_SW, R_S0, R_T0, 16'h0000));
      // Patch point: byte lane
      emit(i_type(OP_SB, R_S0, R_T1, {14'b0, lane}));
      emit(i_type(OP_LW, R_S0, R_T2, 16'h0000));
      emit(i_type(OP_LB, R_S0, R_T3, {14'b0, lane}));
      emit(i_type(OP_LBU, R_S0, R_V0, {14'b0, lane}));
      emit(r_type(R_V0, R_T2, R_V0, NO_SH, FN_XOR));
      emit(r_type(R_V0, R_T3, R_V0, NO_SH, FN_ADDU));
      emit_halt();
    end
    PROG_SLOT:
    begin
      emit(i_type(OP_ADDIU, R_ZERO, R_T0, 16'h0005));
      emit(i_type(OP_BEQ, R_T0, R_T0, 16'h0002));
      emit(i_type(OP_ADDIU, R_V0, R_V0, 16'h0001));
      // Skipped by the taken beq
      emit(i_type(OP_ADDIU, R_V0, R_V0, 16'h0010));
      emit(i_type(OP_BNE, R_T0, R_T0, 16'h0002));
      emit(i_type(OP_ADDIU, R_V0, R_V0, 16'h0100));
      emit(i_type(OP_ADDIU, R_V0, R_V0, 16'h1000));
      emit_halt();
    end
    PROG_CALL:
    begin
      emit({OP_JAL, call_target[27:2]});
      emit(i_type(OP_ADDIU, R_ZERO, R_V0, 16'h0001));
      // Return lands here, v0 gains the link value
      emit(r_type(R_V0, R_RA, R_V0, NO_SH, FN_ADDU));
      emit_halt();
      // Subroutine at word 5
      emit(i_type(OP_ADDIU, R_V0, R_V0, 16'h0040));
      emit(r_type(R_RA, R_ZERO, R_ZERO, NO_SH, FN_JR));
      emit(i_type(OP_ADDIU, R_V0, R_V0, 16'h0200));
    end
    default:
    begin
      emit_operands(a, b);
      emit(i_type(OP_ADDIU, R_ZERO, R_S0, 16'h0100));
      emit(r_type(R_T0, R_T1, R_ZERO, NO_SH, FN_MULTU));
      emit(r_type(R_ZERO, R_ZERO, R_T2, NO_SH, FN_MFHI));
      emit(r_type(R_ZERO, R_ZERO, R_V0, NO_SH, FN_MFLO));
      emit(i_type(OP_SW, R_S0, R_T2, 16'h0000));
      emit_halt();
    end
  endcase
endtask

`endif

/* tb_mips_cpu_harvard.sv */
`timescale 1ns/1ps

module tb_mips_cpu_harvard;

  import mips_pkg::*;

  localparam int NUM_ROWS = 13;
  // sb $zero, 0x100($zero)
  localparam logic [31:0] STRAY_WORD = 32'hA000_0100;

  typedef struct packed {
    logic [2:0]  prog;
    logic        rand_ops;
    logic        toggle_en;
    logic [1:0]  lane;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_v0;
    logic [31:0] exp_word;
  } row_t;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  logic [31:0] rom [0:1023];
  logic [31:0] ram [0:1023];
  logic [31:0] rng_state = 32'd21628;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 1000000;

  `include "tb_programs.svh"

  // Random rows get their expected values from the model below
  row_t rows [NUM_ROWS] = '{
    '{PROG_ALU,  1'b1, 1'b0, 2'd0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{PROG_ALU,  1'b1, 1'b1, 2'd0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{PROG_MEM,  1'b0, 1'b0, 2'd1, 32'h1122_3344, 32'h0000_00F0, 32'h1122_F0A4, 32'h1122_F044},
    '{PROG_MEM,  1'b1, 1'b0, 2'd0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{PROG_MEM,  1'b1, 1'b1, 2'd2, 32'h0, 32'h0, 32'h0, 32'h0},
    '{PROG_MEM,  1'b1, 1'b0, 2'd3, 32'h0, 32'h0, 32'h0, 32'h0},
    '{PROG_SLOT, 1'b0, 1'b0, 2'd0, 32'h0, 32'h0, 32'h0000_1101, 32'hA583_FFBF},
    '{PROG_SLOT, 1'b0, 1'b1, 2'd0, 32'h0, 32'h0, 32'h0000_1101, 32'hA583_FFBF},
    '{PROG_CALL, 1'b0, 1'b0, 2'd0, 32'h0, 32'h0, 32'hBFC0_0249, 32'hA583_FFBF},
    '{PROG_CALL, 1'b0, 1'b1, 2'd0, 32'h0, 32'h0, 32'hBFC0_0249, 32'hA583_FFBF},
    '{PROG_MULT, 1'b0, 1'b0, 2'd0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFE},
    '{PROG_MULT, 1'b1, 1'b0, 2'd0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{PROG_MULT, 1'b1, 1'b1, 2'd0, 32'h0, 32'h0, 32'h0, 32'h0}
  };

  mips_cpu_harvard u_dut (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  always #10 clk = ~clk;

  // ROM window at the reset vector, a nop at address 0
  // Anywhere else the bus shows a byte store that a halted core must not retire
  assign instr_readdata = (instr_address[31:12] == RESET_VECTOR[31:12])
                          ? rom[instr_address[11:2]]
                          : (instr_address == 32'd0) ? 32'h0000_0000 : STRAY_WORD;
  // RAM drives read data only for a read strobe
  assign data_readdata  = data_read ? ram[data_address[11:2]] : 32'h0000_0000;

  always @(posedge clk)
  begin
    if (clk_enable && data_write)
    begin
      ram[data_address[11:2]] <= data_writedata;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Every word distinct over the whole index
  function automatic logic [31:0] fill_word(input int idx);
    logic [15:0] low;
    low = idx[15:0];
    return {low ^ 16'hA5C3, ~low};
  endfunction

  // Two's complement order decided by the sign bits first
  function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic logic [31:0] alu_fold(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    r = a + b;
    r ^= a - b;
    r ^= a & b;
    r ^= a | b;
    r ^= a ^ b;
    r ^= ~(a | b);
    r ^= {31'b0, less_signed(a, b)};
    r ^= {31'b0, a < b};
    r ^= b << 5;
    r ^= b >> 7;
    // Sign bit copied into the eleven vacated positions
    r ^= (b >> 11) | ({32{b[31]}} << 21);
    r ^= a + 32'hFFFF_8765;
    r ^= {31'b0, less_signed(a, 32'hFFFF_8000)};
    r ^= {31'b0, a < 32'hFFFF_FFF0};
    r ^= a & 32'h0000_F0F0;
    r ^= a | 32'h0000_1234;
    r ^= a ^ 32'h0000_FF00;
    r ^= 32'hBEEF_0000;
    return r;
  endfunction

  // Expected v0 and RAM word at 0x100 for random rows
  task automatic model_row(inout row_t row);
    logic [31:0] merged;
    logic [7:0]  bval;
    logic [63:0] product;
    merged = row.a;
    bval   = row.b[7:0];
    merged[row.lane*8 +: 8] = bval;
    product = {32'b0, row.a} * {32'b0, row.b};
    row.exp_word = fill_word(64);
    case (row.prog)
      PROG_ALU: row.exp_v0 = alu_fold(row.a, row.b);
      PROG_MEM:
      begin
        row.exp_v0   = ({24'b0, bval} ^ merged) + {{24{bval[7]}}, bval};
        row.exp_word = merged;
      end
      default:
      begin
        row.exp_v0   = product[31:0];
        row.exp_word = product[63:32];
      end
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic run_row(input int idx);
    row_t        row;
    logic        en_used;
    logic [31:0] snap_addr;
    logic [31:0] snap_v0;
    row = rows[idx];
    if (row.rand_ops)
    begin
      rng_state = xorshift32(rng_state);
      row.a     = rng_state;
      rng_state = xorshift32(rng_state);
      row.b     = rng_state;
      model_row(row);
    end
    load_program(row.prog, row.a, row.b, row.lane);
    for (int i = 0; i < 1024; i++)
    begin
      ram[i] = fill_word(i);
    end
    @(posedge clk);
    reset      <= 1'b1;
    clk_enable <= 1'b0;
    repeat (8) @(posedge clk);
    reset      <= 1'b0;
    clk_enable <= 1'b1;
    @(negedge clk);
    snap_addr = instr_address;
    snap_v0   = register_v0;
    do
    begin
      @(posedge clk);
      en_used = clk_enable;
      if (row.toggle_en)
      begin
        rng_state = xorshift32(rng_state);
        clk_enable <= rng_state[0];
      end
      else
      begin
        clk_enable <= 1'b1;
      end
      @(negedge clk);
      // Stalled edge must leave the core untouched
      if (!en_used)
      begin
        check_value("instr_address", instr_address, snap_addr);
        check_value("register_v0", register_v0, snap_v0);
      end
      snap_addr = instr_address;
      snap_v0   = register_v0;
    end
    while (active);
    // A few enabled edges after the halt
    repeat (4)
    begin
      @(posedge clk);
      clk_enable <= 1'b1;
      @(negedge clk);
      assert (!data_write && !data_read && active === 1'b0)
      else
      begin
        errors++;
        $display("Row %0d: core touched RAM or woke up after halting", idx);
      end
    end
    check_value("register_v0", register_v0, row.exp_v0);
    check_value("ram[0x100]", ram[64], row.exp_word);
  endtask

  initial
  begin
    int total_len;
    clk        = 1'b0;
    reset      = 1'b1;
    clk_enable = 1'b0;
    total_len  = 0;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      load_program(rows[i].prog, 32'h0, 32'h0, 2'd0);
      total_len += prog_pos;
    end
    // Four cycles per word, reset and halt tail per row, and a margin
    cycle_limit = total_len * 4 + NUM_ROWS * 16 + 200;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      run_row(i);
    end
    $display("Run finished with %0d errors in %0d cycles", errors, cycles);
    if (errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* mips_cpu_harvard.sv */
`timescale 1ns/1ps

module mips_cpu_harvard (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,
  input  logic        clk_enable,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  import mips_pkg::*;

  fetch_t      fetch;
  redirect_t   redirect;
  ctrl_t       ctrl;
  operands_t   operands;
  logic [4:0]  rs_addr;
  logic [4:0]  rt_addr;
  logic [31:0] rs_val;
  logic [31:0] rt_val;
  logic [31:0] alu_result;
  logic [31:0] hi;
  logic [31:0] lo;
  logic        write_en;
  logic [31:0] write_data;

  // PC drives the instruction port directly
  mips_fetch u_fetch (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .redirect   (redirect),
    .pc         (instr_address),
    .fetch      (fetch),
    .active     (active)
  );

  // Fetched word enters decode as the instruction union
  mips_decode u_decode (
    .instr    (instr_readdata),
    .active   (active),
    .rs_val   (rs_val),
    .rt_val   (rt_val),
    .rs_addr  (rs_addr),
    .rt_addr  (rt_addr),
    .ctrl     (ctrl),
    .operands (operands)
  );

  mips_regfile u_regfile (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .rs_addr     (rs_addr),
    .rt_addr     (rt_addr),
    .rd_addr     (ctrl.dest_reg),
    .write_en    (write_en),
    .write_data  (write_data),
    .rs_val      (rs_val),
    .rt_val      (rt_val),
    .register_v0 (register_v0)
  );

  mips_execute u_execute (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .ctrl       (ctrl),
    .operands   (operands),
    .fetch      (fetch),
    .instr      (instr_readdata),
    .alu_result (alu_result),
    .redirect   (redirect),
    .hi         (hi),
    .lo         (lo)
  );

  // Data port and register write-back
  mips_mem_writeback u_mem_writeback (
    .ctrl           (ctrl),
    .alu_result     (alu_result),
    .rt_val         (rt_val),
    .hi             (hi),
    .lo             (lo),
    .fetch          (fetch),
    .data_readdata  (data_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_read      (data_read),
    .data_write     (data_write),
    .write_en       (write_en),
    .write_data     (write_data)
  );

endmodule

/* mips_mem_writeback.sv */
`timescale 1ns/1ps

module mips_mem_writeback (
  input  mips_pkg::ctrl_t  ctrl,
  input  logic [31:0]      alu_result,
  input  logic [31:0]      rt_val,
  input  logic [31:0]      hi,
  input  logic [31:0]      lo,
  input  mips_pkg::fetch_t fetch,
  input  logic [31:0]      data_readdata,
  output logic [31:0]      data_address,
  output logic [31:0]      data_writedata,
  output logic             data_read,
  output logic             data_write,
  output logic             write_en,
  output logic [31:0]      write_data
);

  import mips_pkg::*;

  logic [1:0]  offset;
  logic [7:0]  load_byte;
  logic [31:0] load_value;
  logic [31:0] byte_merged;

  // Word aligned bus address, byte lane kept aside
  assign offset       = alu_result[1:0];
  assign data_address = {alu_result[31:2], 2'b00};

  // sb reads the old word to merge into
  assign data_read  = (ctrl.mem_op == MEM_LW) || (ctrl.mem_op == MEM_LB)
                      || (ctrl.mem_op == MEM_LBU) || (ctrl.mem_op == MEM_SB);
  assign data_write = (ctrl.mem_op == MEM_SW) || (ctrl.mem_op == MEM_SB);

  // Lane 0 is bits 7:0
  always_comb
  begin
    byte_merged = data_readdata;
    case (offset)
      2'd0: byte_merged[7:0]   = rt_val[7:0];
      2'd1: byte_merged[15:8]  = rt_val[7:0];
      2'd2: byte_merged[23:16] = rt_val[7:0];
      default: byte_merged[31:24] = rt_val[7:0];
    endcase
  end

  assign data_writedata = (ctrl.mem_op == MEM_SB) ? byte_merged : rt_val;

  // Same lane order for byte loads
  assign load_byte = data_readdata[offset*8 +: 8];

  always_comb
  begin
    case (ctrl.mem_op)
      MEM_LB:  load_value = {{24{load_byte[7]}}, load_byte};
      MEM_LBU: load_value = {24'b0, load_byte};
      default: load_value = data_readdata;
    endcase
  end

  assign write_en = ctrl.reg_write;

  always_comb
  begin
    case (ctrl.wb_src)
      WB_MEM:  write_data = load_value;
      WB_LINK: write_data = fetch.pc_plus8;
      WB_HI:   write_data = hi;
      WB_LO:   write_data = lo;
      default: write_data = alu_result;
    endcase
  end

  // Word stores must be aligned
  a_sw_aligned: assert final (
    !(data_write && (ctrl.mem_op == MEM_SW) && (offset != 2'd0))
  );

endmodule

/* mips_execute.sv */
`timescale 1ns/1ps

module mips_execute (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk_enable,
  input  mips_pkg::ctrl_t     ctrl,
  input  mips_pkg::operands_t operands,
  input  mips_pkg::fetch_t    fetch,
  input  mips_pkg::instr_t    instr,
  output logic [31:0]         alu_result,
  output mips_pkg::redirect_t redirect,
  output logic [31:0]         hi,
  output logic [31:0]         lo
);

  import mips_pkg::*;

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        operands_equal;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [63:0] product;

  assign op_a = operands.rs_val;
  // Immediate or rt as the second operand
  assign op_b = ctrl.alu_src_imm ? operands.imm32 : operands.rt_val;

  always_comb
  begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_AND:  alu_result = op_a & op_b;
      ALU_OR:   alu_result = op_a | op_b;
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_NOR:  alu_result = ~(op_a | op_b);
      ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      // Shifts act on rt by shamt
      ALU_SLL:  alu_result = op_b << operands.shamt;
      ALU_SRL:  alu_result = op_b >> operands.shamt;
      ALU_SRA:  alu_result = $unsigned($signed(op_b) >>> operands.shamt);
      ALU_LUI:  alu_result = {operands.imm32[15:0], 16'b0};
      default:  alu_result = op_a + op_b;
    endcase
  end

  // Compare on the raw register values
  assign operands_equal = (operands.rs_val == operands.rt_val);

  // Relative to the delay slot address
  assign branch_target = fetch.pc_plus4 + {operands.imm32[29:0], 2'b00};
  // Region bits from PC+4
  assign jump_target = {fetch.pc_plus4[31:28], instr.j.target, 2'b00};

  always_comb
  begin
    redirect.valid  = 1'b0;
    redirect.target = branch_target;
    case (ctrl.branch)
      BR_BEQ: redirect.valid = operands_equal;
      BR_BNE: redirect.valid = !operands_equal;
      BR_J:
      begin
        redirect.valid  = 1'b1;
        redirect.target = jump_target;
      end
      BR_JR:
      begin
        redirect.valid  = 1'b1;
        redirect.target = operands.rs_val;
      end
      default: ;
    endcase
  end

  // Unsigned 32x32 product
  assign product = {32'b0, operands.rs_val} * {32'b0, operands.rt_val};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (clk_enable && ctrl.hilo_write)
    begin
      hi <= product[63:32];
      lo <= product[31:0];
    end
  end

endmodule

/* mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  rd_addr,
  input  logic        write_en,
  input  logic [31:0] write_data,
  output logic [31:0] rs_val,
  output logic [31:0] rt_val,
  output logic [31:0] register_v0
);

  // Entry 0 exists but is never written
  logic [31:0] regs [0:31];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (clk_enable && write_en && (rd_addr != 5'd0))
    begin
      regs[rd_addr] <= write_data;
    end
  end

  // Combinational reads straight from the array
  assign rs_val = regs[rs_addr];
  assign rt_val = regs[rt_addr];

  // $v0 tap for the outside world
  assign register_v0 = regs[2];

  // $zero keeps its reset value through every write
  a_zero_reg: assert property (
    @(posedge clk) disable iff (reset)
    ((rs_addr != 5'd0) || (rs_val == '0)) && ((rt_addr != 5'd0) || (rt_val == '0))
  );

endmodule

/* mips_decode.sv */
`timescale 1ns/1ps

module mips_decode (
  input  mips_pkg::instr_t    instr,
  input  logic                active,
  input  logic [31:0]         rs_val,
  input  logic [31:0]         rt_val,
  output logic [4:0]          rs_addr,
  output logic [4:0]          rt_addr,
  output mips_pkg::ctrl_t     ctrl,
  output mips_pkg::operands_t operands
);

  import mips_pkg::*;

  // Source fields sit at the same place in R and I forms
  assign rs_addr = instr.r.rs;
  assign rt_addr = instr.r.rt;

  always_comb
  begin
    // Defaults: no writes, no memory, I-type destination
    ctrl          = '0;
    ctrl.alu_op   = ALU_ADD;
    ctrl.wb_src   = WB_ALU;
    ctrl.mem_op   = MEM_NONE;
    ctrl.branch   = BR_NONE;
    ctrl.dest_reg = instr.i.rt;

    case (instr.r.op)
      OP_SPECIAL:
      begin
        ctrl.dest_reg  = instr.r.rd;
        ctrl.reg_write = 1'b1;
        case (instr.r.funct)
          FN_SLL:  ctrl.alu_op = ALU_SLL;
          FN_SRL:  ctrl.alu_op = ALU_SRL;
          FN_SRA:  ctrl.alu_op = ALU_SRA;
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_NOR:  ctrl.alu_op = ALU_NOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_SLTU: ctrl.alu_op = ALU_SLTU;
          FN_MFHI: ctrl.wb_src = WB_HI;
          FN_MFLO: ctrl.wb_src = WB_LO;
          FN_JR:
          begin
            ctrl.reg_write = 1'b0;
            ctrl.branch    = BR_JR;
          end
          FN_MULTU:
          begin
            ctrl.reg_write  = 1'b0;
            ctrl.hilo_write = 1'b1;
          end
          // Unknown function code retires as a no-op
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_J:   ctrl.branch = BR_J;
      OP_JAL:
      begin
        ctrl.branch    = BR_J;
        ctrl.reg_write = 1'b1;
        ctrl.dest_reg  = REG_RA;
        ctrl.wb_src    = WB_LINK;
      end
      OP_BEQ: ctrl.branch = BR_BEQ;
      OP_BNE: ctrl.branch = BR_BNE;
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
      begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        case (instr.i.op)
          OP_SLTI:  ctrl.alu_op = ALU_SLT;
          OP_SLTIU: ctrl.alu_op = ALU_SLTU;
          OP_ANDI:  ctrl.alu_op = ALU_AND;
          OP_ORI:   ctrl.alu_op = ALU_OR;
          OP_XORI:  ctrl.alu_op = ALU_XOR;
          OP_LUI:   ctrl.alu_op = ALU_LUI;
          default:  ctrl.alu_op = ALU_ADD;
        endcase
        // Logical immediates are zero extended
        ctrl.imm_zero_ext = (instr.i.op == OP_ANDI) || (instr.i.op == OP_ORI)
                            || (instr.i.op == OP_XORI);
      end
      OP_LW, OP_LB, OP_LBU:
      begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.wb_src      = WB_MEM;
        ctrl.mem_op      = (instr.i.op == OP_LW) ? MEM_LW
                         : (instr.i.op == OP_LB) ? MEM_LB : MEM_LBU;
      end
      OP_SW, OP_SB:
      begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_op      = (instr.i.op == OP_SW) ? MEM_SW : MEM_SB;
      end
      default: ;
    endcase

    // Halted core retires nothing
    if (!active)
    begin
      ctrl.reg_write  = 1'b0;
      ctrl.hilo_write = 1'b0;
      ctrl.mem_op     = MEM_NONE;
      ctrl.branch     = BR_NONE;
    end
  end

  assign operands.rs_val = rs_val;
  assign operands.rt_val = rt_val;
  assign operands.shamt  = instr.r.shamt;
  assign operands.imm32  = ctrl.imm_zero_ext ? {16'b0, instr.i.imm}
                                             : {{16{instr.i.imm[15]}}, instr.i.imm};

endmodule

/* mips_fetch.sv */
`timescale 1ns/1ps

module mips_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk_enable,
  input  mips_pkg::redirect_t redirect,
  output logic [31:0]         pc,
  output mips_pkg::fetch_t    fetch,
  output logic                active
);

  import mips_pkg::*;

  // Target waiting for the delay slot to retire
  logic        pending_valid;
  logic [31:0] pending_target;
  logic [31:0] pc_next;

  assign fetch.pc_plus4 = pc + 32'd4;
  assign fetch.pc_plus8 = pc + 32'd8;

  // Pending target wins over sequential flow
  assign pc_next = pending_valid ? pending_target : fetch.pc_plus4;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc            <= RESET_VECTOR;
      pending_valid <= 1'b0;
      active        <= 1'b1;
    end
    else if (clk_enable)
    begin
      pc            <= pc_next;
      pending_valid <= redirect.valid;
      // Halt once address 0 has been fetched
      if (pc == 32'd0)
      begin
        active <= 1'b0;
      end
    end
  end

  // Target register only loads when a redirect is taken
  always_ff @(posedge clk)
  begin
    if (clk_enable && redirect.valid)
    begin
      pending_target <= redirect.target;
    end
  end

  // No branch or jump inside a delay slot
  a_no_nested_redirect: assert property (
    @(posedge clk) disable iff (reset)
    (clk_enable && pending_valid) |-> !redirect.valid
  );

endmodule

/* mips_pkg.sv */
package mips_pkg;

  // First fetch address after reset
  localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;
  // Link register for jal
  localparam logic [4:0] REG_RA = 5'd31;

  // Primary opcodes kept in the subset
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0A,
    OP_SLTIU   = 6'h0B,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LB      = 6'h20,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_SB      = 6'h28,
    OP_SW      = 6'h2B
  } opcode_e;

  // SPECIAL function codes
  typedef enum logic [5:0] {
    FN_SLL   = 6'h00,
    FN_SRL   = 6'h02,
    FN_SRA   = 6'h03,
    FN_JR    = 6'h08,
    FN_MFHI  = 6'h10,
    FN_MFLO  = 6'h12,
    FN_MULTU = 6'h19,
    FN_ADDU  = 6'h21,
    FN_SUBU  = 6'h23,
    FN_AND   = 6'h24,
    FN_OR    = 6'h25,
    FN_XOR   = 6'h26,
    FN_NOR   = 6'h27,
    FN_SLT   = 6'h2A,
    FN_SLTU  = 6'h2B
  } funct_e;

  // One fetched word, three overlapping views
  typedef union packed {
    struct packed {
      opcode_e    op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      funct_e     funct;
    } r;
    struct packed {
      opcode_e     op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
    struct packed {
      opcode_e     op;
      logic [25:0] target;
    } j;
  } instr_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } alu_op_e;

  // Register write source; link is PC+8
  typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_LINK, WB_HI, WB_LO} wb_src_e;

  typedef enum logic [2:0] {MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB} mem_op_e;

  typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JR} branch_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src_imm;
    logic       imm_zero_ext;
    logic       reg_write;
    logic [4:0] dest_reg;
    wb_src_e    wb_src;
    mem_op_e    mem_op;
    branch_e    branch;
    logic       hilo_write;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm32;
    logic [4:0]  shamt;
  } operands_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  typedef struct packed {
    logic [31:0] pc_plus4;
    logic [31:0] pc_plus8;
  } fetch_t;

endpackage
